// ==== ni_send.f ====
verilog/ni_pkg.sv
verilog/ni_regs.sv
verilog/ni_chan_dma.sv
verilog/ni_send_mux.sv
verilog/ni_credit_count.sv
verilog/ni_send.sv
test/ni_send_properties.sv
test/ni_send_tb.sv

// ==== test/ni_send_properties.sv ====
// send interface protocol assertions
module ni_send_properties import ni_pkg::*; (
    input logic              clk,
    input logic              reset,
    input logic              flit_wr_o,
    input logic              m_stb_o,
    input logic              m_ack_i,
    input logic [MEM_AW-1:0] m_addr_o,
    input logic              s_ack_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;  // failed assertions so far

    a_flit_wr_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(flit_wr_o))
    else begin
        $error("flit_wr_o is unknown");
        fail_cnt++;
    end

    // a waiting read keeps its strobe and address
    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        m_stb_o && !m_ack_i |=> m_stb_o && $stable(m_addr_o))
    else begin
        $error("memory address changed during a stalled read");
        fail_cnt++;
    end

    a_ack_single: assert property (@(posedge clk) disable iff (reset)
        s_ack_o |=> !s_ack_o)
    else begin
        $error("host acknowledge high for two cycles");
        fail_cnt++;
    end

endmodule

// ==== test/ni_send_tb.sv ====
// send interface testbench
module ni_send_tb import ni_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_VC = 4;
    localparam int BUF_DEPTH = 4;
    localparam int CH_W = vc_idx_w(NUM_VC);
    localparam int ADDR_W = CH_W + REG_AW;

    logic               clk = 1'b0;
    logic               reset;
    logic               s_stb_i, s_we_i;
    logic [ADDR_W-1:0]  s_addr_i;
    logic [DATA_W-1:0]  s_dat_i, s_dat_o, m_dat_i;
    logic               s_ack_o, m_stb_o, m_ack_i, flit_wr_o, irq_o;
    logic [MEM_AW-1:0]  m_addr_o;
    flit_t              flit_o;
    logic [NUM_VC-1:0]  flit_vc_o, credit_i;
    logic [EADDR_W-1:0] src_addr_i;

    logic [31:0]        lfsr = 32'd75507;
    logic               irq_en = 1'b0;
    logic               slow_credit = 1'b0;
    int                 mem_wait = 0;
    int                 out_cnt [NUM_VC];
    // reference model state per channel
    logic [MEM_AW-1:0]  exp_addr [NUM_VC];
    int                 exp_left [NUM_VC];
    logic [EADDR_W-1:0] exp_dest [NUM_VC];
    logic [NUM_VC-1:0]  exp_hdr = '0;
    logic [NUM_VC-1:0]  exp_active = '0;
    logic               in_pkt = 1'b0;
    logic [NUM_VC-1:0]  cur_vc = '0;

    ni_send #(.NUM_VC(NUM_VC), .BUF_DEPTH(BUF_DEPTH)) i_ni_send (.*);

    bind ni_send ni_send_properties i_props (.*);

    always #5 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [DATA_W-1:0] mem_value(input logic [MEM_AW-1:0] a);
        return {a ^ 16'hc35a, ~a};
    endfunction

    task automatic abort_run(input string why);
        $display("error: %s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            abort_run("value check failed");
        end
    endtask

    task automatic host_xfer(input logic we, input int ch, input reg_field_e f,
                             input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] rd);
        int n;
        n = 0;
        @(posedge clk);
        s_stb_i  <= 1'b1;
        s_we_i   <= we;
        s_addr_i <= {CH_W'(ch), f};
        s_dat_i  <= d;
        do begin
            @(posedge clk);
            n++;
            if (n > 20) begin
                abort_run("timeout waiting for host acknowledge");
            end
        end while (!s_ack_o);
        rd = s_dat_o;  // status is stable before the edge
        s_stb_i <= 1'b0;
        s_we_i  <= 1'b0;
    endtask

    task automatic write_reg(input int ch, input reg_field_e f, input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] unused;
        host_xfer(1'b1, ch, f, d, unused);
    endtask

    task automatic program_channel(input int ch, input logic [MEM_AW-1:0] addr,
                                   input int size, input logic [EADDR_W-1:0] dest);
        write_reg(ch, REG_START_ADDR, DATA_W'(addr));
        write_reg(ch, REG_SIZE, DATA_W'(size));
        write_reg(ch, REG_DEST, DATA_W'(dest));
        exp_addr[ch]   = addr;
        exp_left[ch]   = size;
        exp_dest[ch]   = dest;
        exp_hdr[ch]    = 1'b1;
        exp_active[ch] = 1'b1;
    endtask

    task automatic start_channel(input int ch);
        write_reg(ch, REG_CTRL, {29'd0, irq_en, 2'b01});
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (exp_active != '0) begin
            @(posedge clk);
            n++;
            if (n > limit) begin
                abort_run("timeout waiting for packets to complete");
            end
        end
        repeat (2) @(posedge clk);
    endtask

    // memory model, ack after 0 to 3 cycles
    always @(posedge clk) begin
        if (reset) begin
            m_ack_i <= 1'b0;
        end else if (m_ack_i) begin
            m_ack_i  <= 1'b0;
            mem_wait <= int'(rand_bits(2));
        end else if (m_stb_o) begin
            if (mem_wait == 0) begin
                m_ack_i <= 1'b1;
                m_dat_i <= mem_value(m_addr_o);
            end else begin
                mem_wait <= mem_wait - 1;
            end
        end
    end

    // router model returns credits at random
    always @(posedge clk) begin
        int nxt;
        if (reset) begin
            credit_i <= '0;
        end else begin
            for (int i = 0; i < NUM_VC; i++) begin
                nxt = out_cnt[i] + int'(flit_wr_o & flit_vc_o[i]) - int'(credit_i[i]);
                check(nxt <= BUF_DEPTH, 1, "outstanding flits within buffer depth");
                out_cnt[i] = nxt;
                credit_i[i] <= (nxt > 0) && (rand_bits(slow_credit ? 3 : 1) == 0);
            end
        end
    end

    // flit monitor against the reference model
    always @(posedge clk) begin
        int c;
        flit_flag_e fl;
        if (!reset && flit_wr_o) begin
            check($onehot(flit_vc_o), 1, "flit_vc_o one-hot");
            c = $clog2(flit_vc_o);
            if (in_pkt) begin
                check(flit_vc_o, cur_vc, "flit vc inside a packet");
            end
            check(exp_active[c], 1, "flit from a channel with no packet");
            if (exp_hdr[c]) begin
                check({flit_o.flag, flit_o.payload},
                      {HDR_FLAG, 16'h0, src_addr_i, exp_dest[c]}, "header flit");
                exp_hdr[c] = 1'b0;
                in_pkt = 1'b1;
                cur_vc = flit_vc_o;
            end else begin
                fl = (exp_left[c] == 1) ? TAIL_FLAG : BDY_FLAG;
                check({flit_o.flag, flit_o.payload}, {fl, mem_value(exp_addr[c])}, "data flit");
                exp_addr[c] = exp_addr[c] + 1'b1;
                exp_left[c] = exp_left[c] - 1;
                if (exp_left[c] == 0) begin
                    exp_active[c] = 1'b0;
                    in_pkt = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (i_ni_send.i_props.fail_cnt != 0) begin
            abort_run("protocol assertion failed");
        end
    end

    initial begin : stim
        logic [DATA_W-1:0]  st;
        logic [MEM_AW-1:0]  a;
        logic [EADDR_W-1:0] d;
        int                 sz;
        reset = 1'b1;
        s_stb_i = 1'b0;
        s_we_i = 1'b0;
        s_addr_i = '0;
        s_dat_i = '0;
        m_ack_i = 1'b0;
        m_dat_i = '0;
        credit_i = '0;
        src_addr_i = 8'h3c;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // one packet with the interrupt off
        program_channel(0, 16'h0100, 5, 8'h11);
        start_channel(0);
        wait_idle(500);
        host_xfer(1'b0, 0, REG_CTRL, '0, st);
        check(st[12:0], 13'h0010, "status after first packet");
        check(irq_o, 0, "irq with enable off");
        write_reg(0, REG_CTRL, 32'h4);
        @(posedge clk);
        check(irq_o, 1, "irq with enable on");
        write_reg(0, REG_CTRL, 32'h6);  // clear, keep enable
        @(posedge clk);
        check(irq_o, 0, "irq after clear");
        irq_en = 1'b1;

        // all channels at once, fast then slow credits
        for (int r = 0; r < 4; r++) begin
            slow_credit = r[0];
            for (int c = 0; c < NUM_VC; c++) begin
                a = MEM_AW'(rand_bits(16));
                d = EADDR_W'(rand_bits(8));
                sz = int'(rand_bits(4)) + 1;
                program_channel(c, a, sz, d);
            end
            for (int c = 0; c < NUM_VC; c++) begin
                start_channel(c);
            end
            wait_idle(5000);
            host_xfer(1'b0, 2, REG_CTRL, '0, st);
            check(st[12:0], 13'h10f0, "status after all channels");
            check(irq_o, 1, "irq on done flags");
            for (int c = 0; c < NUM_VC; c++) begin
                write_reg(c, REG_CTRL, 32'h6);
            end
            @(posedge clk);
            check(irq_o, 0, "irq after clearing all");
        end

        // refused starts, empty packet and busy channel
        write_reg(1, REG_SIZE, 32'd0);
        start_channel(1);
        program_channel(2, 16'h0400, 12, 8'h22);
        start_channel(2);
        write_reg(2, REG_SIZE, 32'd3);
        start_channel(2);
        wait_idle(2000);
        host_xfer(1'b0, 3, REG_CTRL, '0, st);
        check(st[12:0], 13'h1640, "error and done flags");
        check(irq_o, 1, "irq on error flags");

        repeat (5) @(posedge clk);
        if (i_ni_send.i_props.fail_cnt == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("protocol assertion failed");
        end
    end

endmodule

// ==== verilog/ni_chan_dma.sv ====
// virtual channel send engine
module ni_chan_dma import ni_pkg::*; #(
    parameter int NUM_VC = 4
) (
    input  logic      clk,
    input  logic      reset,
    input  cfg_wr_t   cfg_i,
    input  logic      cfg_sel_i,
    input  logic      full_i,
    input  logic      taken_i,
    output chan_req_t req_o,
    output chan_evt_t evt_o
);

    chan_state_e        state_q;
    logic [MEM_AW-1:0]  start_addr_q;
    logic [SIZE_W-1:0]  size_q;
    logic [EADDR_W-1:0] dest_q;
    logic [MEM_AW-1:0]  cur_addr;
    logic [SIZE_W-1:0]  remain;
    logic [EADDR_W-1:0] cur_dest;
    logic               my_wr;
    logic               start_req;
    logic               start_ok;
    logic               last_word;

    if (NUM_VC < 1) begin : g_vc_check
        $error("at least one virtual channel is needed");
    end

    assign my_wr     = cfg_i.valid & cfg_sel_i;
    assign start_req = my_wr && (cfg_i.field == REG_CTRL) && cfg_i.data[0];
    assign start_ok  = start_req && (state_q == CH_IDLE) && (size_q != '0);
    assign last_word = (remain == SIZE_W'(1));

    // host side configuration
    always_ff @(posedge clk) begin
        if (my_wr) begin
            case (cfg_i.field)
                REG_START_ADDR: start_addr_q <= cfg_i.data[MEM_AW-1:0];
                REG_SIZE:       size_q       <= cfg_i.data[SIZE_W-1:0];
                REG_DEST:       dest_q       <= cfg_i.data[EADDR_W-1:0];
                default:        ;  // ctrl handled below
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= CH_IDLE;
        end else begin
            case (state_q)
                CH_IDLE: begin
                    if (start_ok) begin
                        state_q <= CH_HDR;
                    end
                end
                CH_HDR: begin
                    if (taken_i) begin
                        state_q <= CH_DATA;
                    end
                end
                CH_DATA: begin
                    if (taken_i && last_word) begin
                        state_q <= CH_IDLE;
                    end
                end
                default: state_q <= CH_IDLE;
            endcase
        end
    end

    // running copies, so the host may reprogram while busy
    always_ff @(posedge clk) begin
        if (start_ok) begin
            cur_addr <= start_addr_q;
            remain   <= size_q;
            cur_dest <= dest_q;
        end else if (taken_i && state_q == CH_DATA) begin
            cur_addr <= cur_addr + MEM_AW'(1);
            remain   <= remain - SIZE_W'(1);
        end
    end

    always_comb begin
        req_o.busy       = (state_q != CH_IDLE);
        req_o.flit_valid = (state_q != CH_IDLE) & ~full_i;  // hold while downstream full
        req_o.is_hdr     = (state_q == CH_HDR);
        req_o.is_tail    = (state_q == CH_DATA) & last_word;
        req_o.mem_addr   = cur_addr;
        req_o.dest       = cur_dest;
    end

    // busy start or empty packet is refused
    always_comb begin
        evt_o.done = taken_i & (state_q == CH_DATA) & last_word;
        evt_o.err  = start_req & ((state_q != CH_IDLE) | (size_q == '0));
    end

endmodule

// ==== verilog/ni_credit_count.sv ====
// downstream buffer occupancy per channel
module ni_credit_count #(
    parameter int NUM_VC = 4,
    parameter int BUF_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [NUM_VC-1:0] wr_i,
    input  logic [NUM_VC-1:0] credit_i,
    output logic [NUM_VC-1:0] full_o
);

    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    for (genvar i = 0; i < NUM_VC; i++) begin : g_vc
        logic [CNT_W-1:0] depth;

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                depth <= '0;
            end else begin
                case ({wr_i[i], credit_i[i]})
                    2'b10:   depth <= depth + CNT_W'(1);
                    2'b01:   depth <= depth - CNT_W'(1);
                    default: ;  // both or neither, no change
                endcase
            end
        end

        assign full_o[i] = (depth == CNT_W'(BUF_DEPTH));
    end

endmodule

// ==== verilog/ni_pkg.sv ====
// send-side network interface definitions
package ni_pkg;

    localparam int DATA_W  = 32;  // data word and flit payload
    localparam int MEM_AW  = 16;  // memory word address
    localparam int EADDR_W = 8;   // endpoint address
    localparam int SIZE_W  = 10;  // packet word count
    localparam int REG_AW  = 2;   // register field inside a channel block

    // flit kind, same encoding as the network side
    typedef enum logic [1:0] {
        BDY_FLAG  = 2'b00,
        TAIL_FLAG = 2'b01,
        HDR_FLAG  = 2'b10
    } flit_flag_e;

    // register fields of one channel block
    typedef enum logic [REG_AW-1:0] {
        REG_START_ADDR = 2'd0,
        REG_SIZE       = 2'd1,
        REG_DEST       = 2'd2,
        REG_CTRL       = 2'd3
    } reg_field_e;

    typedef enum logic [1:0] {
        CH_IDLE,
        CH_HDR,
        CH_DATA
    } chan_state_e;

    // decoded host write, broadcast to all channels
    typedef struct packed {
        reg_field_e          field;
        logic [DATA_W-1:0]   data;
        logic                valid;
    } cfg_wr_t;

    // channel request toward the arbiter
    typedef struct packed {
        logic                busy;
        logic                flit_valid;  // credit available, flit may go
        logic                is_hdr;
        logic                is_tail;
        logic [MEM_AW-1:0]   mem_addr;
        logic [EADDR_W-1:0]  dest;
    } chan_req_t;

    typedef struct packed {
        logic done;
        logic err;
    } chan_evt_t;

    // outgoing flit, vc bits travel beside it
    typedef struct packed {
        flit_flag_e          flag;
        logic [DATA_W-1:0]   payload;
    } flit_t;

    // channel index width, at least one bit
    function automatic int vc_idx_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

// ==== verilog/ni_regs.sv ====
// host register decoder and interrupt
module ni_regs import ni_pkg::*; #(
    parameter int NUM_VC = 4,
    localparam int CH_W = vc_idx_w(NUM_VC),
    localparam int ADDR_W = CH_W + REG_AW
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              s_stb_i,
    input  logic              s_we_i,
    input  logic [ADDR_W-1:0] s_addr_i,
    input  logic [DATA_W-1:0] s_dat_i,
    output logic              s_ack_o,
    output logic [DATA_W-1:0] s_dat_o,
    input  logic [NUM_VC-1:0] busy_i,
    input  chan_evt_t         evt_i [NUM_VC],
    output cfg_wr_t           cfg_o,
    output logic [NUM_VC-1:0] cfg_sel_o,
    output logic              irq_o
);

    localparam int STAT_W = 3 * NUM_VC + 1;

    logic [CH_W-1:0]   ch_idx;
    reg_field_e        field;
    logic              wr_fire;
    logic [NUM_VC-1:0] done_flag;
    logic [NUM_VC-1:0] err_flag;
    logic [NUM_VC-1:0] done_evt;
    logic [NUM_VC-1:0] err_evt;
    logic [NUM_VC-1:0] clr;
    logic              int_en;
    logic              ctrl_wr;
    logic [STAT_W-1:0] status;

    if (STAT_W > DATA_W) begin : g_stat_check
        $error("status word does not fit the data bus");
    end

    assign ch_idx  = s_addr_i[ADDR_W-1:REG_AW];
    assign field   = reg_field_e'(s_addr_i[REG_AW-1:0]);
    assign wr_fire = s_stb_i & s_ack_o & s_we_i;  // one write per transfer
    assign ctrl_wr = wr_fire && (field == REG_CTRL);

    // channel index to one-hot select
    always_comb begin
        for (int i = 0; i < NUM_VC; i++) begin
            cfg_sel_o[i] = (ch_idx == CH_W'(i));
        end
    end

    always_comb begin
        cfg_o.field = field;
        cfg_o.data  = s_dat_i;
        cfg_o.valid = wr_fire;
    end

    always_comb begin
        for (int i = 0; i < NUM_VC; i++) begin
            done_evt[i] = evt_i[i].done;
            err_evt[i]  = evt_i[i].err;
        end
    end

    assign clr = (ctrl_wr && s_dat_i[1]) ? cfg_sel_o : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s_ack_o   <= 1'b0;
            done_flag <= '0;
            err_flag  <= '0;
            int_en    <= 1'b0;
        end else begin
            s_ack_o   <= s_stb_i & ~s_ack_o;  // single cycle ack
            done_flag <= (done_flag & ~clr) | done_evt;  // a new event beats the clear
            err_flag  <= (err_flag & ~clr) | err_evt;
            if (ctrl_wr) begin
                int_en <= s_dat_i[2];
            end
        end
    end

    assign status = {int_en, err_flag, done_flag, busy_i};

    // only the control field reads back
    always_comb begin
        s_dat_o = '0;
        if (field == REG_CTRL) begin
            s_dat_o[STAT_W-1:0] = status;
        end
    end

    assign irq_o = int_en & ((|done_flag) | (|err_flag));

endmodule

// ==== verilog/ni_send.sv ====
// multi-channel DMA send interface
module ni_send import ni_pkg::*; #(
    parameter int NUM_VC = 4,
    parameter int BUF_DEPTH = 4,
    localparam int ADDR_W = vc_idx_w(NUM_VC) + REG_AW
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               s_stb_i,
    input  logic               s_we_i,
    input  logic [ADDR_W-1:0]  s_addr_i,
    input  logic [DATA_W-1:0]  s_dat_i,
    output logic               s_ack_o,
    output logic [DATA_W-1:0]  s_dat_o,
    output logic               m_stb_o,
    output logic [MEM_AW-1:0]  m_addr_o,
    input  logic [DATA_W-1:0]  m_dat_i,
    input  logic               m_ack_i,
    output flit_t              flit_o,
    output logic [NUM_VC-1:0]  flit_vc_o,
    output logic               flit_wr_o,
    input  logic [NUM_VC-1:0]  credit_i,
    input  logic [EADDR_W-1:0] src_addr_i,
    output logic               irq_o
);

    cfg_wr_t           cfg;
    logic [NUM_VC-1:0] cfg_sel;
    logic [NUM_VC-1:0] busy;
    logic [NUM_VC-1:0] full;
    logic [NUM_VC-1:0] taken;
    chan_req_t         req [NUM_VC];
    chan_evt_t         evt [NUM_VC];

    ni_regs #(.NUM_VC(NUM_VC)) i_regs (
        .clk(clk), .reset(reset),
        .s_stb_i(s_stb_i), .s_we_i(s_we_i), .s_addr_i(s_addr_i), .s_dat_i(s_dat_i),
        .s_ack_o(s_ack_o), .s_dat_o(s_dat_o),
        .busy_i(busy), .evt_i(evt),
        .cfg_o(cfg), .cfg_sel_o(cfg_sel), .irq_o(irq_o)
    );

    for (genvar i = 0; i < NUM_VC; i++) begin : g_chan
        ni_chan_dma #(.NUM_VC(NUM_VC)) i_chan (
            .clk(clk), .reset(reset),
            .cfg_i(cfg), .cfg_sel_i(cfg_sel[i]),
            .full_i(full[i]), .taken_i(taken[i]),
            .req_o(req[i]), .evt_o(evt[i])
        );
        assign busy[i] = req[i].busy;
    end

    ni_send_mux #(.NUM_VC(NUM_VC)) i_mux (
        .clk(clk), .reset(reset),
        .req_i(req), .src_addr_i(src_addr_i),
        .m_ack_i(m_ack_i), .m_dat_i(m_dat_i), .m_stb_o(m_stb_o), .m_addr_o(m_addr_o),
        .grant_o(), .taken_o(taken),  // taken is one-hot per flit
        .flit_o(flit_o), .flit_vc_o(flit_vc_o), .flit_wr_o(flit_wr_o)
    );

    ni_credit_count #(.NUM_VC(NUM_VC), .BUF_DEPTH(BUF_DEPTH)) i_credit (
        .clk(clk), .reset(reset),
        .wr_i(taken), .credit_i(credit_i), .full_o(full)
    );

endmodule

// ==== verilog/ni_send_mux.sv ====
// round-robin channel arbiter and flit builder
module ni_send_mux import ni_pkg::*; #(
    parameter int NUM_VC = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  chan_req_t          req_i [NUM_VC],
    input  logic [EADDR_W-1:0] src_addr_i,
    input  logic               m_ack_i,
    input  logic [DATA_W-1:0]  m_dat_i,
    output logic               m_stb_o,
    output logic [MEM_AW-1:0]  m_addr_o,
    output logic [NUM_VC-1:0]  grant_o,
    output logic [NUM_VC-1:0]  taken_o,
    output flit_t              flit_o,
    output logic [NUM_VC-1:0]  flit_vc_o,
    output logic               flit_wr_o
);

    localparam int CH_W = vc_idx_w(NUM_VC);

    logic [CH_W-1:0]   grant_idx;
    logic              grant_vld;
    logic [CH_W-1:0]   next_idx;
    logic              next_found;
    logic [NUM_VC-1:0] busy_vec;
    logic              hold;
    chan_req_t         sel;
    logic              hdr_go;
    logic              data_go;

    always_comb begin
        for (int i = 0; i < NUM_VC; i++) begin
            busy_vec[i] = req_i[i].busy;
        end
    end

    assign hold = grant_vld & busy_vec[grant_idx];  // keep until packet ends

    // search starts just after the last grant
    always_comb begin
        int cand;
        next_idx   = grant_idx;
        next_found = 1'b0;
        for (int k = 1; k <= NUM_VC; k++) begin
            cand = (int'(grant_idx) + k) % NUM_VC;
            if (!next_found && busy_vec[cand]) begin
                next_idx   = CH_W'(cand);
                next_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant_idx <= CH_W'(NUM_VC - 1);  // channel 0 wins first
            grant_vld <= 1'b0;
        end else if (!hold) begin
            grant_idx <= next_idx;
            grant_vld <= next_found;
        end
    end

    assign grant_o = grant_vld ? (NUM_VC'(1) << grant_idx) : '0;
    assign sel     = req_i[grant_idx];

    // memory read only in the data phase
    assign m_stb_o  = grant_vld & sel.busy & ~sel.is_hdr & sel.flit_valid;
    assign m_addr_o = sel.mem_addr;

    assign hdr_go    = grant_vld & sel.flit_valid & sel.is_hdr;
    assign data_go   = m_stb_o & m_ack_i;
    assign flit_wr_o = hdr_go | data_go;
    assign taken_o   = flit_wr_o ? grant_o : '0;
    assign flit_vc_o = grant_o;

    always_comb begin
        if (sel.is_hdr) begin
            flit_o.flag    = HDR_FLAG;
            flit_o.payload = {{(DATA_W - 2 * EADDR_W){1'b0}}, src_addr_i, sel.dest};
        end else begin
            flit_o.flag    = sel.is_tail ? TAIL_FLAG : BDY_FLAG;
            flit_o.payload = m_dat_i;
        end
    end

endmodule
